//--- hw/rv_mini_params.svh
`ifndef RV_MINI_PARAMS_SVH
`define RV_MINI_PARAMS_SVH

// RAM depth in 32-bit words, indexed by byte address bits 11:2
`define RAM_WORDS 1024

// PC value after reset
`define BOOT_ADDR 32'h0000_0080

// memory mapped test peripherals, only decoded on data writes
`define PERIPH_PASS_ADDR 32'h2000_0000
`define PERIPH_FAIL_ADDR 32'h2000_0004
`define PERIPH_EXIT_ADDR 32'h2000_0008

`endif

//--- hw/rv_mini_pkg.sv
package rv_mini_pkg;

    // base opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_ILLEGAL
    } instr_class_e;

    typedef enum logic [1:0] {
        BR_EQ,
        BR_NE,
        BR_LT
    } branch_cond_e;

    typedef struct packed {
        instr_class_e iclass;
        alu_op_e      alu_op;
        branch_cond_e br_cond;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [4:0]   rd;
        logic         we;
        logic [31:0]  imm;
        logic         use_imm;
    } decoded_instr_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic [3:0]  be;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] wb_val;
        logic [31:0] next_pc;
        logic        taken;
    } exec_result_t;

endpackage

//--- hw/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_mini_pkg::*; (
    input  logic [31:0]    instr_i,
    output decoded_instr_t dec_o
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        has_rd;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        dec_o.iclass  = CLS_ILLEGAL;
        dec_o.alu_op  = ALU_ADD;
        dec_o.br_cond = BR_EQ;
        dec_o.rs1     = instr_i[19:15];
        dec_o.rs2     = instr_i[24:20];
        dec_o.rd      = instr_i[11:7];
        dec_o.imm     = imm_i;
        dec_o.use_imm = 1'b0;
        has_rd        = 1'b0;

        case (opcode)
            OPC_OP: begin
                has_rd = 1'b1;
                dec_o.iclass = CLS_ALU;
                case ({funct7, funct3})
                    10'b0000000_000: dec_o.alu_op = ALU_ADD;
                    10'b0100000_000: dec_o.alu_op = ALU_SUB;
                    10'b0000000_111: dec_o.alu_op = ALU_AND;
                    10'b0000000_110: dec_o.alu_op = ALU_OR;
                    10'b0000000_100: dec_o.alu_op = ALU_XOR;
                    10'b0000000_010: dec_o.alu_op = ALU_SLT;
                    default:         dec_o.iclass = CLS_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                has_rd = 1'b1;
                dec_o.iclass = CLS_ALU;
                dec_o.use_imm = 1'b1;
                case (funct3)
                    3'b000:  dec_o.alu_op = ALU_ADD;
                    3'b111:  dec_o.alu_op = ALU_AND;
                    3'b110:  dec_o.alu_op = ALU_OR;
                    3'b100:  dec_o.alu_op = ALU_XOR;
                    3'b010:  dec_o.alu_op = ALU_SLT;
                    // shifts and SLTIU are outside the subset
                    default: dec_o.iclass = CLS_ILLEGAL;
                endcase
            end
            OPC_LUI: begin
                has_rd = 1'b1;
                dec_o.iclass = CLS_ALU;
                dec_o.alu_op = ALU_PASS_B;
                dec_o.imm = imm_u;
                dec_o.use_imm = 1'b1;
            end
            OPC_LOAD: begin
                has_rd = 1'b1;
                dec_o.use_imm = 1'b1;
                // only full word accesses exist, LB/LH/LBU/LHU trap as illegal
                dec_o.iclass = (funct3 == 3'b010) ? CLS_LOAD : CLS_ILLEGAL;
            end
            OPC_STORE: begin
                dec_o.imm = imm_s;
                dec_o.use_imm = 1'b1;
                dec_o.iclass = (funct3 == 3'b010) ? CLS_STORE : CLS_ILLEGAL;
            end
            OPC_BRANCH: begin
                dec_o.imm = imm_b;
                dec_o.iclass = CLS_BRANCH;
                case (funct3)
                    3'b000:  dec_o.br_cond = BR_EQ;
                    3'b001:  dec_o.br_cond = BR_NE;
                    3'b100:  dec_o.br_cond = BR_LT;
                    default: dec_o.iclass = CLS_ILLEGAL;
                endcase
            end
            OPC_JAL: begin
                has_rd = 1'b1;
                dec_o.iclass = CLS_JAL;
                dec_o.imm = imm_j;
            end
            OPC_JALR: begin
                has_rd = 1'b1;
                dec_o.iclass = (funct3 == 3'b000) ? CLS_JALR : CLS_ILLEGAL;
            end
            default: dec_o.iclass = CLS_ILLEGAL;
        endcase

        // x0 is never written and an illegal instruction writes nothing
        dec_o.we = has_rd && (dec_o.rd != 5'd0) && (dec_o.iclass != CLS_ILLEGAL);
    end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_mini_pkg::*; (
    input  decoded_instr_t dec_i,
    input  logic [31:0]    pc_i,
    input  logic [31:0]    rs1_val_i,
    input  logic [31:0]    rs2_val_i,
    output exec_result_t   res_o,
    output mem_req_t       mem_o
);

    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic        less_than;
    logic        cond_ok;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    logic [31:0] jalr_sum;

    // branches never select the immediate, so op_b is rs2 for BLT
    assign op_b      = dec_i.use_imm ? dec_i.imm : rs2_val_i;
    assign less_than = $signed(rs1_val_i) < $signed(op_b);

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_res = rs1_val_i + op_b;
            ALU_SUB:    alu_res = rs1_val_i - op_b;
            ALU_AND:    alu_res = rs1_val_i & op_b;
            ALU_OR:     alu_res = rs1_val_i | op_b;
            ALU_XOR:    alu_res = rs1_val_i ^ op_b;
            ALU_SLT:    alu_res = {31'b0, less_than};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = 32'b0;
        endcase
    end

    always_comb begin
        case (dec_i.br_cond)
            BR_EQ:   cond_ok = (rs1_val_i == rs2_val_i);
            BR_NE:   cond_ok = (rs1_val_i != rs2_val_i);
            BR_LT:   cond_ok = less_than;
            default: cond_ok = 1'b0;
        endcase
    end

    assign pc_plus4  = pc_i + 32'd4;
    // branch and JAL targets are both PC relative
    assign pc_target = pc_i + dec_i.imm;
    assign jalr_sum  = rs1_val_i + dec_i.imm;

    always_comb begin
        taken         = 1'b0;
        res_o.wb_val  = alu_res;
        res_o.next_pc = pc_plus4;
        case (dec_i.iclass)
            CLS_BRANCH: begin
                taken = cond_ok;
                if (cond_ok) begin
                    res_o.next_pc = pc_target;
                end
            end
            CLS_JAL: begin
                taken         = 1'b1;
                res_o.wb_val  = pc_plus4;
                res_o.next_pc = pc_target;
            end
            CLS_JALR: begin
                taken         = 1'b1;
                res_o.wb_val  = pc_plus4;
                res_o.next_pc = {jalr_sum[31:1], 1'b0};
            end
            default: begin
                taken = 1'b0;
            end
        endcase
        res_o.taken = taken;
    end

    // loads and stores decode as ADD with the immediate, so the ALU gives the address
    assign mem_o.addr  = alu_res;
    assign mem_o.wdata = rs2_val_i;
    assign mem_o.we    = (dec_i.iclass == CLS_STORE);
    assign mem_o.be    = 4'hf;

endmodule

//--- hw/rv_result.sv
`timescale 1ns/1ns

`include "rv_mini_params.svh"

module rv_result import rv_mini_pkg::*; (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  decoded_instr_t dec_i,
    input  exec_result_t   res_i,
    input  logic [31:0]    load_data_i,
    input  logic           commit_i,
    output logic [31:0]    pc_o,
    output logic [31:0]    rs1_val_o,
    output logic [31:0]    rs2_val_o
);

    // x0 has no storage, reads of it are forced to zero below
    logic [31:0] regs [1:31];
    logic [31:0] pc_q;
    logic [31:0] wb_data;

    assign wb_data = (dec_i.iclass == CLS_LOAD) ? load_data_i : res_i.wb_val;

    always_ff @(posedge clk_i) begin
        // the decoder clears we for rd == 0, so the index stays in range
        if (commit_i && dec_i.we) begin
            regs[dec_i.rd] <= wb_data;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `BOOT_ADDR;
        end else if (commit_i) begin
            pc_q <= res_i.next_pc;
        end
    end

    assign pc_o = pc_q;

    assign rs1_val_o = (dec_i.rs1 == 5'd0) ? 32'd0 : regs[dec_i.rs1];
    assign rs2_val_o = (dec_i.rs2 == 5'd0) ? 32'd0 : regs[dec_i.rs2];

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_mini_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        fetch_enable_i,

    output logic        instr_req_o,
    output logic [31:0] instr_addr_o,
    input  logic        instr_gnt_i,
    input  logic        instr_rvalid_i,
    input  logic [31:0] instr_rdata_i,

    output logic        data_req_o,
    output mem_req_t    data_o,
    input  logic        data_gnt_i,
    input  logic        data_rvalid_i,
    input  logic [31:0] data_rdata_i
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT_I,
        S_EXEC,
        S_WAIT_D,
        S_HALT
    } seq_state_e;

    seq_state_e     state_q;
    seq_state_e     state_d;
    logic [31:0]    instr_q;
    mem_req_t       mem_req;
    mem_req_t       mem_q;
    logic           data_req_q;
    logic           is_mem;
    logic           commit;
    decoded_instr_t dec;
    exec_result_t   res;
    logic [31:0]    pc;
    logic [31:0]    rs1_val;
    logic [31:0]    rs2_val;

    rv_decode decode_i (
        .instr_i (instr_q),
        .dec_o   (dec)
    );

    rv_execute execute_i (
        .dec_i     (dec),
        .pc_i      (pc),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .res_o     (res),
        .mem_o     (mem_req)
    );

    rv_result result_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dec_i       (dec),
        .res_i       (res),
        .load_data_i (data_rdata_i),
        .commit_i    (commit),
        .pc_o        (pc),
        .rs1_val_o   (rs1_val),
        .rs2_val_o   (rs2_val)
    );

    assign is_mem       = (dec.iclass == CLS_LOAD) || (dec.iclass == CLS_STORE);
    assign instr_req_o  = (state_q == S_FETCH) && fetch_enable_i;
    assign instr_addr_o = pc;
    assign data_req_o   = data_req_q;
    assign data_o       = mem_q;

    always_comb begin
        state_d = state_q;
        commit  = 1'b0;
        case (state_q)
            S_FETCH: begin
                if (instr_req_o && instr_gnt_i) begin
                    state_d = S_WAIT_I;
                end
            end
            S_WAIT_I: begin
                if (instr_rvalid_i) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                if (dec.iclass == CLS_ILLEGAL) begin
                    state_d = S_HALT;
                end else if (is_mem) begin
                    state_d = S_WAIT_D;
                end else begin
                    commit  = 1'b1;
                    state_d = S_FETCH;
                end
            end
            S_WAIT_D: begin
                // stores finish on rvalid as well, it marks completion
                if (!data_req_q && data_rvalid_i) begin
                    commit  = 1'b1;
                    state_d = S_FETCH;
                end
            end
            default: begin
                state_d = S_HALT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_FETCH;
            data_req_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == S_EXEC) && is_mem) begin
                data_req_q <= 1'b1;
            end else if (data_req_q && data_gnt_i) begin
                data_req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_WAIT_I) && instr_rvalid_i) begin
            instr_q <= instr_rdata_i;
        end
        // request payload stays stable while the request waits for its grant
        if (state_q == S_EXEC) begin
            mem_q <= mem_req;
        end
    end

endmodule

//--- hw/mm_ram.sv
`timescale 1ns/1ns

`include "rv_mini_params.svh"

module mm_ram import rv_mini_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,

    input  logic        instr_req_i,
    input  logic [31:0] instr_addr_i,
    output logic        instr_gnt_o,
    output logic        instr_rvalid_o,
    output logic [31:0] instr_rdata_o,

    input  logic        data_req_i,
    input  mem_req_t    data_i,
    output logic        data_gnt_o,
    output logic        data_rvalid_o,
    output logic [31:0] data_rdata_o,

    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic [31:0] exit_value_o,
    output logic        exit_valid_o
);

    localparam int ADDR_MSB = $clog2(`RAM_WORDS) + 1;

    logic [31:0] mem [0:`RAM_WORDS-1];

    logic data_wr;
    logic hit_pass;
    logic hit_fail;
    logic hit_exit;
    logic ram_wr;

    // both ports accept a request in the cycle it appears
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    assign data_wr  = data_req_i && data_i.we;
    assign hit_pass = (data_i.addr == `PERIPH_PASS_ADDR);
    assign hit_fail = (data_i.addr == `PERIPH_FAIL_ADDR);
    assign hit_exit = (data_i.addr == `PERIPH_EXIT_ADDR);
    assign ram_wr   = data_wr && !(hit_pass || hit_fail || hit_exit);

    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            instr_rdata_o <= mem[instr_addr_i[ADDR_MSB:2]];
        end
        if (ram_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (data_i.be[b]) begin
                    mem[data_i.addr[ADDR_MSB:2]][8*b +: 8] <= data_i.wdata[8*b +: 8];
                end
            end
        end
        if (data_req_i && !data_i.we) begin
            data_rdata_o <= mem[data_i.addr[ADDR_MSB:2]];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= 32'd0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
            // peripheral outputs are single cycle pulses
            tests_passed_o <= data_wr && hit_pass;
            tests_failed_o <= data_wr && hit_fail;
            exit_valid_o   <= data_wr && hit_exit;
            if (data_wr && hit_exit) begin
                exit_value_o <= data_i.wdata;
            end
        end
    end

endmodule

//--- hw/riscv_wrapper.sv
`timescale 1ns/1ns

module riscv_wrapper import rv_mini_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        fetch_enable_i,
    output logic        tests_passed_o,
    output logic        tests_failed_o,
    output logic [31:0] exit_value_o,
    output logic        exit_valid_o
);

    // instruction port
    logic        instr_req;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_addr;
    logic [31:0] instr_rdata;

    // data port
    logic        data_req;
    logic        data_gnt;
    logic        data_rvalid;
    mem_req_t    data;
    logic [31:0] data_rdata;

    rv_core core_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata),
        .data_req_o     (data_req),
        .data_o         (data),
        .data_gnt_i     (data_gnt),
        .data_rvalid_i  (data_rvalid),
        .data_rdata_i   (data_rdata)
    );

    // RAM plus the pass, fail and exit test peripherals
    mm_ram ram_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_i         (data),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_value_o   (exit_value_o),
        .exit_valid_o   (exit_valid_o)
    );

endmodule

//--- tests/riscv_wrapper_assert.sv
`timescale 1ns/1ns

module riscv_wrapper_assert (
    input logic clk_i,
    input logic arst_n_i,
    input logic instr_req_i,
    input logic instr_gnt_i,
    input logic instr_rvalid_i,
    input logic data_req_i,
    input logic data_gnt_i,
    input logic data_rvalid_i,
    input logic tests_passed_i,
    input logic tests_failed_i,
    input logic exit_valid_i
);

    // the RAM grants in the same cycle as the request
    instr_gnt_is_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_gnt_i == instr_req_i)
        else $error("instruction grant differs from the request");

    instr_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (instr_req_i && instr_gnt_i) |=> instr_rvalid_i)
        else $error("instruction rvalid missing one cycle after the grant");

    data_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (data_req_i && data_gnt_i) |=> data_rvalid_i)
        else $error("data rvalid missing one cycle after the grant");

    exit_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        exit_valid_i |=> !exit_valid_i)
        else $error("exit_valid_o high on two consecutive cycles");

    pass_fail_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(tests_passed_i && tests_failed_i))
        else $error("tests_passed_o and tests_failed_o high together");

endmodule

bind riscv_wrapper riscv_wrapper_assert assert_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_req_i    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .data_req_i     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .tests_passed_i (tests_passed_o),
    .tests_failed_i (tests_failed_o),
    .exit_valid_i   (exit_valid_o)
);

//--- tests/tb_riscv_wrapper.sv
`timescale 1ns/1ns

`include "rv_mini_params.svh"

module tb_riscv_wrapper;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int AW = $clog2(`RAM_WORDS);

    logic        clk;
    logic        arst_n;
    logic        fetch_enable;
    logic        tests_passed;
    logic        tests_failed;
    logic [31:0] exit_value;
    logic        exit_valid;

    integer           seed;
    integer           fd;
    integer           code;
    integer           test_id;
    integer           fetch_level;
    integer           test_errors;
    integer           errors;
    integer           tests_run;
    integer           tests_bad;
    logic             in_test;
    logic             running;
    logic [31:0]      kind;
    logic [31:0]      addr;
    logic [31:0]      value;
    logic [8*128-1:0] line;

    riscv_wrapper dut_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .fetch_enable_i (fetch_enable),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_value_o   (exit_value),
        .exit_valid_o   (exit_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("FAIL test %0d: %s expected 0x%08h got 0x%08h", test_id, name,
                     expected, actual);
            test_errors++;
        end
    endtask

    // holds the core in reset and refills the whole RAM before the program is loaded
    task automatic begin_test();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        fetch_enable = 1'b0;
        for (int a = 0; a < `RAM_WORDS; a++) begin
            dut_i.ram_i.mem[a[AW-1:0]] = 32'hA5A5_0000 ^ a;
        end
        test_errors = 0;
        in_test = 1'b1;
        running = 1'b0;
    endtask

    task automatic start_run();
        int idle;
        if (!running) begin
            repeat (2) @(posedge clk);
            #1;
            arst_n = 1'b1;
            check_value("exit_value_o", exit_value, 32'd0);
            check_value("exit_valid_o", 32'(exit_valid), 32'd0);
            check_value("tests_passed_o", 32'(tests_passed), 32'd0);
            check_value("tests_failed_o", 32'(tests_failed), 32'd0);
            // a few idle cycles between reset release and fetch enable
            idle = $unsigned($random(seed)) % 8;
            repeat (idle) @(posedge clk);
            #1;
            fetch_enable = (fetch_level != 0);
            running = 1'b1;
        end
    endtask

    // outputs are registered pulses, so the falling edge sees each one exactly once
    task automatic wait_for_event(output logic found);
        int cycles;
        found = 1'b0;
        cycles = 0;
        while (!found && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            found = exit_valid || tests_passed || tests_failed;
        end
    endtask

    task automatic expect_exit(input logic [31:0] expected);
        logic found;
        start_run();
        wait_for_event(found);
        assert (found) else begin
            $display("test %0d: no exit value appeared within %0d cycles", test_id,
                     TIMEOUT_CYCLES);
            test_errors++;
        end
        if (found) begin
            check_value("exit_valid_o", 32'(exit_valid), 32'd1);
            check_value("exit_value_o", exit_value, expected);
            check_value("tests_failed_o", 32'(tests_failed), 32'd0);
        end
    endtask

    task automatic expect_flag(input logic want_pass);
        logic found;
        start_run();
        wait_for_event(found);
        assert (found) else begin
            $display("test %0d: neither pass nor fail was signalled within %0d cycles",
                     test_id, TIMEOUT_CYCLES);
            test_errors++;
        end
        if (found) begin
            check_value("tests_passed_o", 32'(tests_passed), 32'(want_pass));
            check_value("tests_failed_o", 32'(tests_failed), 32'(!want_pass));
        end
    endtask

    task automatic expect_silence();
        logic found;
        start_run();
        wait_for_event(found);
        assert (!found) else begin
            $display("test %0d: a peripheral output became active %s", test_id,
                     "although the core should stay silent");
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (in_test) begin
            assert (running) else begin
                $display("test %0d: the test data gives no expected result", test_id);
                test_errors++;
            end
            tests_run++;
            errors += test_errors;
            if (test_errors == 0) begin
                $display("test %0d: ok", test_id);
            end else begin
                tests_bad++;
                $display("test %0d: %0d check(s) failed", test_id, test_errors);
            end
            in_test = 1'b0;
        end
    endtask

    initial begin
        seed = 91011;
        arst_n = 1'b0;
        fetch_enable = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        test_errors = 0;
        test_id = 0;
        fetch_level = 0;
        in_test = 1'b0;
        running = 1'b0;
        fd = $fopen("tests/wrapper_testdata.hex", "r");
        if (fd == 0) begin
            $display("could not open tests/wrapper_testdata.hex");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kind);
                if (code == 1) begin
                    if (kind[7:0] == "#") begin
                        code = $fgets(line, fd);
                    end else if (kind == "test") begin
                        close_test();
                        code = $fscanf(fd, "%d %d", test_id, fetch_level);
                        begin_test();
                    end else if (kind == "word") begin
                        code = $fscanf(fd, "%h %h", addr, value);
                        dut_i.ram_i.mem[addr[AW-1:0]] = value;
                    end else if (kind == "exit") begin
                        code = $fscanf(fd, "%h", value);
                        expect_exit(value);
                    end else if (kind == "pass" || kind == "fail") begin
                        expect_flag(kind == "pass");
                    end else if (kind == "none") begin
                        expect_silence();
                    end else begin
                        $display("unknown record in the test data file");
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        close_test();
        $display("%0d tests run, %0d with errors, %0d failed checks", tests_run, tests_bad,
                 errors);
        if (errors == 0 && tests_run > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tests/wrapper_testdata.hex
# records: test <id> <fetch enable> | word <word address> <instruction>
# expectations in order: exit <value> | pass | fail | none (no output within the timeout)
# arithmetic, exit value 0x12345000 + ((77 & 103) ^ (77 | 103)) + (-13 < 90)
test 1 1
word 20 05a00093
word 21 ff300113
word 22 002081b3
word 23 40208233
word 24 0041f333
word 25 0041e3b3
word 26 00734433
word 27 001124b3
word 28 123455b7
word 29 00858533
word 2a 00950533
word 2b 200002b7
word 2c 00a2a423
exit 1234502b
# memory, stores 0x123 and -512 at 0x400, loads both back and exits with the sum
test 2 1
word 20 40000093
word 21 12300113
word 22 e0000193
word 23 0020a023
word 24 0030a223
word 25 0000a203
word 26 0040a303
word 27 00620533
word 28 200002b7
word 29 00a2a423
exit ffffff23
# control flow, five loop passes each calling a subroutine, exit with 5 + 5
test 3 1
word 20 200002b7
word 21 00000093
word 22 00500113
word 23 00000393
word 24 00108093
word 25 0200036f
word 26 fe20cce3
word 27 00208463
word 28 0002a223
word 29 00708533
word 2a 00a2a423
word 2b 0002a023
word 2c 0000006f
word 2d 00138393
word 2e 00039463
word 2f 0002a223
word 30 00030067
exit 0000000a
pass
# fail peripheral
test 4 1
word 20 200002b7
word 21 0002a223
word 22 0000006f
fail
# fetch disabled, the program would signal pass at once
test 5 0
word 20 200002b7
word 21 0002a023
word 22 0000006f
none
# illegal opcode ahead of the exit and pass stores
test 6 1
word 20 200002b7
word 21 05500513
word 22 00000000
word 23 00a2a423
word 24 0002a023
none

//--- sources.f
+incdir+hw
hw/rv_mini_pkg.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
hw/mm_ram.sv
hw/riscv_wrapper.sv
tests/riscv_wrapper_assert.sv
tests/tb_riscv_wrapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_wrapper
FLIST     ?= sources.f
OBJ_DIR   ?= ./obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
